// ==== mcu_cmd_pkg.sv ====
package mcu_cmd_pkg;

  // host command codes, one byte each
  typedef logic [7:0] cmd_t;

  localparam cmd_t CMD_SET_DATA0 = 8'h10; // data byte 0, low half of write word
  localparam cmd_t CMD_SET_DATA1 = 8'h11; // data byte 1, high half
  localparam cmd_t CMD_SET_ADDR0 = 8'h12; // address bits 7:0
  localparam cmd_t CMD_SET_ADDR1 = 8'h13; // address bits 15:8
  localparam cmd_t CMD_SET_ADDR2 = 8'h14; // address bits 23:16
  localparam cmd_t CMD_VGA_640   = 8'h21; // 640x480
  localparam cmd_t CMD_VGA_1024  = 8'h22; // 1024x768
  localparam cmd_t CMD_VGA_OFF   = 8'h23; // blank display
  localparam cmd_t CMD_VGA_ON    = 8'h24; // unblank display
  localparam cmd_t CMD_MEM_WRITE = 8'hA0; // one word write
  localparam cmd_t CMD_MEM_READ  = 8'hA1; // one word read, answered on int1

  // frame from host: command byte then data byte
  typedef struct packed {
    cmd_t       cmd;
    logic [7:0] dat;
  } cmd_frame_t;

  // frame back to host, data0 goes out first
  typedef struct packed {
    logic [7:0] data1;
    logic [7:0] data0;
  } resp_frame_t;

  // payload bits per frame, both directions
  localparam int FRAME_BITS = 16;

  // int1 steps: start bit, payload, closing zero
  localparam int RESP_STEPS = FRAME_BITS + 2;

endpackage

// ==== mcu_mem_pkg.sv ====
package mcu_mem_pkg;

  localparam int MEM_ADDR_W = 24; // three address bytes
  localparam int MEM_DATA_W = 16; // one word

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;

  // request to the external memory port
  // a read answers with mem_rsp_valid / mem_rsp_data
  typedef struct packed {
    logic      we;    // 1 write, 0 read
    mem_addr_t addr;
    mem_data_t wdata; // ignored on reads
  } mem_req_t;

endpackage

// ==== frame_rx.sv ====
module frame_rx #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    host_strobe,
  input  logic                    host_int0,
  output mcu_cmd_pkg::cmd_frame_t frame,
  output logic                    frame_valid,
  input  logic                    frame_ready,
  output logic                    host_tick
);
  import mcu_cmd_pkg::*;

  localparam int CNT_W = $clog2(FRAME_BITS + 1);

  logic [SYNC_STAGES-1:0][1:0] sync_q;  // {strobe, int0} per stage
  logic                        strobe_s;
  logic                        int0_s;
  logic                        strobe_q; // last synced strobe, edge detect
  logic [CNT_W-1:0]            bit_cnt;  // 0 waits for start bit
  logic [FRAME_BITS-1:0]       shift_q;

  // both pins through the same depth so int0 lines up with its strobe
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sync_q   <= '0;
      strobe_q <= 1'b0;
    end else begin
      sync_q   <= {sync_q[SYNC_STAGES-2:0], {host_strobe, host_int0}};
      strobe_q <= strobe_s;
    end
  end

  assign strobe_s  = sync_q[SYNC_STAGES-1][1];
  assign int0_s    = sync_q[SYNC_STAGES-1][0];
  assign host_tick = strobe_s & ~strobe_q; // rising strobe, one cycle

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      if (frame_valid && frame_ready) begin
        frame_valid <= 1'b0;
      end
      if (host_tick) begin
        if (bit_cnt == '0) begin
          // start bit only counts once the last frame is gone
          if (int0_s && !frame_valid) begin
            bit_cnt <= CNT_W'(1);
          end
        end else if (bit_cnt == CNT_W'(FRAME_BITS)) begin
          bit_cnt     <= '0; // bit 16 in, frame complete
          frame_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // lsb first, so shift right; the first bit ends in bit 0
  always_ff @(posedge sys_clk) begin
    if (host_tick && bit_cnt != '0) begin
      shift_q <= {int0_s, shift_q[FRAME_BITS-1:1]};
    end
  end

  // command came first, so it sits in the low byte
  assign frame.cmd = shift_q[7:0];
  assign frame.dat = shift_q[15:8];

endmodule

// ==== cmd_exec.sv ====
module cmd_exec (
  input  logic                                 sys_clk,
  input  logic                                 sys_rst_n,
  input  mcu_cmd_pkg::cmd_frame_t              frame,
  input  logic                                 frame_valid,
  output logic                                 frame_ready,
  output mcu_mem_pkg::mem_req_t                mem_req,
  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  input  logic                                 mem_rsp_valid,
  input  logic [mcu_mem_pkg::MEM_DATA_W-1:0]   mem_rsp_data,
  output mcu_cmd_pkg::resp_frame_t             resp,
  output logic                                 resp_valid,
  input  logic                                 resp_ready,
  output logic                                 vga_mode,
  output logic                                 vga_block,
  output logic                                 busy
);
  import mcu_cmd_pkg::*;
  import mcu_mem_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, // ready for a frame
    S_EXEC, // one cycle, applies register and display commands
    S_REQ,  // memory request out, waiting for ready
    S_WAIT, // read issued, waiting for the word
    S_RESP  // word held for frame_tx
  } state_t;

  state_t            state;
  cmd_frame_t        cur_q;   // command being executed
  logic [7:0]        data0_q;
  logic [7:0]        data1_q;
  logic [7:0]        addr0_q;
  logic [7:0]        addr1_q;
  logic [7:0]        addr2_q;
  logic [MEM_ADDR_W-1:0] addr_cat;
  logic [MEM_DATA_W-1:0] wdata_cat;
  logic              accept;
  logic              is_mem;

  assign busy        = (state != S_IDLE);
  assign frame_ready = ~busy;             // single command in flight
  assign accept      = frame_valid & frame_ready;
  assign is_mem      = (frame.cmd == CMD_MEM_WRITE) || (frame.cmd == CMD_MEM_READ);

  assign addr_cat  = {addr2_q, addr1_q, addr0_q}; // byte 2 is the top
  assign wdata_cat = {data1_q, data0_q};

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state         <= S_IDLE;
      mem_req_valid <= 1'b0;
      resp_valid    <= 1'b0;
      data0_q       <= '0;
      data1_q       <= '0;
      addr0_q       <= '0;
      addr1_q       <= '0;
      addr2_q       <= '0;
      vga_mode      <= 1'b1; // 1024x768
      vga_block     <= 1'b1; // display blanked
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            if (is_mem) begin
              mem_req_valid <= 1'b1; // request goes out next cycle
              state         <= S_REQ;
            end else begin
              state <= S_EXEC;
            end
          end
        end
        S_EXEC: begin
          case (cur_q.cmd)
            CMD_SET_DATA0: data0_q   <= cur_q.dat;
            CMD_SET_DATA1: data1_q   <= cur_q.dat;
            CMD_SET_ADDR0: addr0_q   <= cur_q.dat;
            CMD_SET_ADDR1: addr1_q   <= cur_q.dat;
            CMD_SET_ADDR2: addr2_q   <= cur_q.dat;
            CMD_VGA_640:   vga_mode  <= 1'b0;
            CMD_VGA_1024:  vga_mode  <= 1'b1;
            CMD_VGA_OFF:   vga_block <= 1'b1;
            CMD_VGA_ON:    vga_block <= 1'b0;
            default: ;     // finished writes and unknown codes just retire
          endcase
          state <= S_IDLE;
        end
        S_REQ: begin
          if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
            // write is done here, retire through S_EXEC
            state <= mem_req.we ? S_EXEC : S_WAIT;
          end
        end
        S_WAIT: begin
          if (mem_rsp_valid) begin
            resp_valid <= 1'b1;
            state      <= S_RESP;
          end
        end
        S_RESP: begin
          if (resp_ready) begin // frame_tx took it
            resp_valid <= 1'b0;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload, loaded once and held through the handshakes
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      cur_q         <= frame;
      mem_req.we    <= (frame.cmd == CMD_MEM_WRITE);
      mem_req.addr  <= addr_cat;
      mem_req.wdata <= wdata_cat;
    end
    if (state == S_WAIT && mem_rsp_valid) begin
      resp.data1 <= mem_rsp_data[15:8];
      resp.data0 <= mem_rsp_data[7:0];
    end
  end

endmodule

// ==== frame_tx.sv ====
module frame_tx (
  input  logic                     sys_clk,
  input  logic                     sys_rst_n,
  input  logic                     host_tick,
  input  mcu_cmd_pkg::resp_frame_t resp,
  input  logic                     resp_valid,
  output logic                     resp_ready,
  output logic                     host_int1
);
  import mcu_cmd_pkg::*;

  localparam int STEP_W = $clog2(RESP_STEPS + 1);

  logic [STEP_W-1:0]     step_q; // 0 idle, else the step due at the next tick
  logic [FRAME_BITS-1:0] bits_q; // bit 0 goes out next
  logic                  take;

  assign resp_ready = (step_q == '0);
  assign take       = resp_valid & resp_ready;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      step_q    <= '0;
      host_int1 <= 1'b0;
    end else begin
      if (take) begin
        step_q <= STEP_W'(1); // armed, start bit at next tick
      end else if (host_tick && step_q != '0) begin
        if (step_q == STEP_W'(1)) begin
          host_int1 <= 1'b1;              // start bit
        end else if (step_q == STEP_W'(RESP_STEPS)) begin
          host_int1 <= 1'b0;              // closing zero
        end else begin
          host_int1 <= bits_q[0];
        end
        if (step_q == STEP_W'(RESP_STEPS)) begin
          step_q <= '0;                   // back to idle
        end else begin
          step_q <= step_q + 1'b1;
        end
      end
    end
  end

  // data0 lsb first, then data1
  always_ff @(posedge sys_clk) begin
    if (take) begin
      bits_q <= {resp.data1, resp.data0};
    end else if (host_tick && step_q > STEP_W'(1) && step_q < STEP_W'(RESP_STEPS)) begin
      bits_q <= bits_q >> 1;
    end
  end

endmodule

// ==== mcu_bridge_top.sv ====
module mcu_bridge_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                               sys_clk,
  input  logic                               sys_rst_n,
  input  logic                               host_strobe,
  input  logic                               host_int0,
  output logic                               host_int1,
  output mcu_mem_pkg::mem_req_t              mem_req,
  output logic                               mem_req_valid,
  input  logic                               mem_req_ready,
  input  logic                               mem_rsp_valid,
  input  logic [mcu_mem_pkg::MEM_DATA_W-1:0] mem_rsp_data,
  output logic                               vga_mode,
  output logic                               vga_block,
  output logic                               busy
);
  import mcu_cmd_pkg::*;

  cmd_frame_t  frame;
  logic        frame_valid;
  logic        frame_ready;
  logic        host_tick;    // shared by both directions
  resp_frame_t resp;
  logic        resp_valid;
  logic        resp_ready;

  // int0 in, frames out
  frame_rx #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_rx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .host_strobe (host_strobe),
    .host_int0   (host_int0),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .host_tick   (host_tick)
  );

  cmd_exec u_exec (
    .sys_clk       (sys_clk),
    .sys_rst_n     (sys_rst_n),
    .frame         (frame),
    .frame_valid   (frame_valid),
    .frame_ready   (frame_ready),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .resp          (resp),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .vga_mode      (vga_mode),
    .vga_block     (vga_block),
    .busy          (busy)
  );

  // read data back out on int1
  frame_tx u_tx (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .host_tick  (host_tick),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .host_int1  (host_int1)
  );

endmodule

// ==== mcu_bridge_assert.sv ====
module mcu_bridge_assert (
  input logic                  sys_clk,
  input logic                  sys_rst_n,
  input mcu_mem_pkg::mem_req_t mem_req,
  input logic                  mem_req_valid,
  input logic                  mem_req_ready,
  input logic                  frame_valid,
  input logic                  frame_ready,
  input logic                  busy,
  input logic                  resp_valid
);

  // request frozen while the port stalls
  req_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    mem_req_valid && !mem_req_ready |=> $stable(mem_req))
    else $error("mem_req changed while waiting for mem_req_ready");

  // one command in flight, an accepted frame keeps the next one out
  ready_vs_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    frame_valid && frame_ready |=> busy && !frame_ready)
    else $error("frame accepted but busy not raised with frame_ready low");

  resp_after_reset: assert property (@(posedge sys_clk)
    $rose(sys_rst_n) |-> !resp_valid)
    else $error("resp_valid high right after reset");

endmodule

bind cmd_exec mcu_bridge_assert u_assert (.*);

// ==== tb_mcu_bridge.sv ====
module tb_mcu_bridge;
  import mcu_cmd_pkg::*;
  import mcu_mem_pkg::*;

  localparam int NUM_TESTS         = 6;
  localparam int STROBES_PER_TEST  = 600; // worst case is the write/read pairs
  localparam int TIMEOUT_CYCLES    = NUM_TESTS * STROBES_PER_TEST * 12 + 4000;

  logic            sys_clk;
  logic            sys_rst_n;
  logic            host_strobe;
  logic            host_int0;
  logic            host_int1;
  mem_req_t        mem_req;
  logic            mem_req_valid;
  logic            mem_req_ready;
  logic            mem_rsp_valid;
  logic [15:0]     mem_rsp_data;
  logic            vga_mode;
  logic            vga_block;
  logic            busy;

  integer          seed = 32'h4f8c_082a;
  logic [15:0]     mem [logic [23:0]]; // memory model contents
  int              req_count;
  int              wr_count;
  logic [23:0]     last_wr_addr;
  logic [15:0]     last_wr_data;
  string           cur_test;
  int              test_errs;          // err_count at test start
  int              test_count;
  int              check_count;
  int              err_count;

  mcu_bridge_top #(
    .SYNC_STAGES (2)
  ) dut0 (
    .sys_clk       (sys_clk),
    .sys_rst_n     (sys_rst_n),
    .host_strobe   (host_strobe),
    .host_int0     (host_int0),
    .host_int1     (host_int1),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .vga_mode      (vga_mode),
    .vga_block     (vga_block),
    .busy          (busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk; // period 8
  end

  // inputs move 1 unit after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("%s done, %0d errors", cur_test, err_count - test_errs);
  endtask

  // one strobe period, int0 steady across the rising edge
  task automatic strobe_bit(input logic b, output logic seen);
    host_int0 = b;
    wait_cycles(6);
    host_strobe = 1'b1;
    wait_cycles(6);
    seen        = host_int1; // settled well after the tick
    host_strobe = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] dat);
    logic [16:0] bits;
    logic        seen;
    bits = {dat, cmd, 1'b1}; // start bit goes first
    for (int i = 0; i < 17; i++) begin
      strobe_bit(bits[i], seen);
    end
    host_int0 = 1'b0;
  endtask

  task automatic recv_frame(output logic [15:0] word);
    logic seen;
    int   n;
    word = '0;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 40) begin // hunt for the start bit
      strobe_bit(1'b0, seen);
      n++;
    end
    if (!seen) begin
      err_count++;
      $display("%s: no start bit on int1 after 40 strobes", cur_test);
    end else begin
      for (int i = 0; i < 16; i++) begin
        strobe_bit(1'b0, seen);
        word[i] = seen; // data0 lsb first, then data1
      end
      strobe_bit(1'b0, seen);
      check("closing bit", 32'd0, {31'd0, seen});
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 200) begin
      wait_cycles(1);
      n++;
    end
    if (busy) begin
      err_count++;
      $display("%s: busy still high after 200 cycles", cur_test);
    end
  endtask

  task automatic load_regs(input logic [23:0] addr, input logic [15:0] data);
    send_frame(CMD_SET_DATA0, data[7:0]);
    send_frame(CMD_SET_DATA1, data[15:8]);
    send_frame(CMD_SET_ADDR0, addr[7:0]);
    send_frame(CMD_SET_ADDR1, addr[15:8]);
    send_frame(CMD_SET_ADDR2, addr[23:16]);
  endtask

  // memory port model, random ready and response delays
  initial begin : mem_model
    int          d;
    mem_req_t    req;
    forever begin
      wait_cycles(1);
      if (mem_req_valid) begin
        d = $unsigned($random(seed)) % 6; // 0..5 cycles to ready
        if (d > 0) wait_cycles(d);
        mem_req_ready = 1'b1;
        req = mem_req;
        wait_cycles(1); // handshake edge
        mem_req_ready = 1'b0;
        req_count++;
        if (req.we) begin
          mem[req.addr] = req.wdata;
          wr_count++;
          last_wr_addr = req.addr;
          last_wr_data = req.wdata;
        end else begin
          d = $unsigned($random(seed)) % 4; // data 1..4 cycles after handshake
          if (d > 0) wait_cycles(d);
          mem_rsp_valid = 1'b1;
          // unwritten words read as a pattern of the whole address
          mem_rsp_data = mem.exists(req.addr) ? mem[req.addr]
                                              : req.addr[15:0] ^ {8'h00, req.addr[23:16]};
          wait_cycles(1);
          mem_rsp_valid = 1'b0;
        end
      end
    end
  end

  task automatic test_reset_state();
    begin_test("test_reset_state");
    check("vga_block", 32'd1, {31'd0, vga_block});
    check("vga_mode", 32'd1, {31'd0, vga_mode});
    check("busy", 32'd0, {31'd0, busy});
    check("int1", 32'd0, {31'd0, host_int1});
    end_test();
  endtask

  task automatic test_display_cmds();
    logic [7:0] cmds [4];
    logic       exp_mode;
    logic       exp_block;
    cmds      = '{8'h21, 8'h24, 8'h22, 8'h23};
    exp_mode  = 1'b1; // reset values
    exp_block = 1'b1;
    begin_test("test_display_cmds");
    for (int i = 0; i < 4; i++) begin
      send_frame(cmds[i], 8'h00);
      wait_idle();
      case (cmds[i])
        8'h21:   exp_mode  = 1'b0;
        8'h22:   exp_mode  = 1'b1;
        8'h23:   exp_block = 1'b1;
        default: exp_block = 1'b0; // 0x24 unblanks
      endcase
      check("vga_mode", {31'd0, exp_mode}, {31'd0, vga_mode});
      check("vga_block", {31'd0, exp_block}, {31'd0, vga_block});
    end
    end_test();
  endtask

  task automatic test_mem_write();
    logic [31:0] r;
    logic [23:0] addr;
    logic [15:0] data;
    int          writes;
    begin_test("test_mem_write");
    r      = $random(seed);
    addr   = r[23:0];
    r      = $random(seed);
    data   = r[15:0];
    writes = wr_count;
    load_regs(addr, data);
    send_frame(CMD_MEM_WRITE, 8'h00);
    wait_idle();
    check("write count", writes + 1, wr_count);
    check("write address", {8'h00, addr}, {8'h00, last_wr_addr});
    check("write data", {16'h0, data}, {16'h0, last_wr_data});
    end_test();
  endtask

  task automatic test_mem_read();
    logic [31:0] r;
    logic [23:0] addr;
    logic [15:0] word;
    begin_test("test_mem_read");
    r    = $random(seed);
    addr = r[23:0];
    r    = $random(seed);
    mem[addr] = r[15:0]; // preload behind the bridge's back
    load_regs(addr, 16'h0000);
    send_frame(CMD_MEM_READ, 8'h00);
    recv_frame(word);
    check("read word", {16'h0, r[15:0]}, {16'h0, word});
    wait_idle();
    end_test();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    logic [23:0] addr;
    logic [15:0] data;
    logic [15:0] word;
    begin_test("test_backpressure");
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      if (i != 2) addr = r[23:0]; // pair 2 overwrites the address of pair 1
      data = r[31:16];
      load_regs(addr, data);
      send_frame(CMD_MEM_WRITE, 8'h00);
      wait_idle();
      send_frame(CMD_MEM_READ, 8'h00);
      wait_idle();
      // tx must already hold the word once busy drops
      check("response taken", 32'd0, {31'd0, dut0.resp_ready});
      recv_frame(word);
      check("read back", {16'h0, data}, {16'h0, word});
    end
    end_test();
  endtask

  task automatic test_unknown_cmd();
    int   reqs;
    int   ones;
    logic seen;
    begin_test("test_unknown_cmd");
    reqs = req_count;
    ones = 0;
    send_frame(8'h55, 8'h5a);
    wait_idle();
    for (int i = 0; i < 20; i++) begin // int1 must stay quiet
      strobe_bit(1'b0, seen);
      if (seen) ones++;
    end
    check("memory requests", reqs, req_count);
    check("int1 high strobes", 32'd0, ones);
    end_test();
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge sys_clk);
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    sys_rst_n     = 1'b0;
    host_strobe   = 1'b0;
    host_int0     = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    wait_cycles(10); // reset held 10 cycles
    sys_rst_n = 1'b1;
    wait_cycles(2);
    test_reset_state();
    test_display_cmds();
    test_mem_write();
    test_mem_read();
    test_backpressure();
    test_unknown_cmd();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
mcu_cmd_pkg.sv
mcu_mem_pkg.sv
frame_rx.sv
cmd_exec.sv
frame_tx.sv
mcu_bridge_top.sv
mcu_bridge_assert.sv
tb_mcu_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mcu_bridge -f sim.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0
